// File: Bender.yml
package:
  name: rename_unit

sources:
  - files:
      - common/rename_pkg.sv
      - common/rename_if.sv
      - rename/map_table.sv
      - rename/free_list.sv
      - rename/checkpoint_store.sv
      - verilog/rename_unit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rename_unit_tb.sv

// File: bench/rename_model.svh
/*
 * Reference model of the rename stage
 * Map table, free queue, checkpoint copies and retire queue
 */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

prf_idx_t m_table  [ARF_SIZE];
prf_idx_t m_free   [$];
prf_idx_t cp_table [CP_SLOTS][ARF_SIZE];
// Free queue at check time, plus everything retired after it
prf_idx_t cp_free  [CP_SLOTS][PRF_SIZE];
int       cp_len   [CP_SLOTS];
int       cp_age   [CP_SLOTS];
logic     cp_live  [CP_SLOTS];
// Pending prev_rd registers and the age of the group that made them
prf_idx_t ret_prf  [$];
int       ret_age  [$];
int       group_age;

task automatic model_reset();
  m_free.delete();
  ret_prf.delete();
  ret_age.delete();
  for (int i = 0; i < ARF_SIZE; i++) begin
    m_table[i] = prf_idx_t'(i);
  end
  for (int i = ARF_SIZE; i < PRF_SIZE; i++) begin
    m_free.push_back(prf_idx_t'(i));
  end
  for (int s = 0; s < CP_SLOTS; s++) begin
    cp_live[s] = 1'b0;
    cp_len[s]  = 0;
    cp_age[s]  = 0;
  end
  group_age = 0;
endtask

function automatic int oldest_live_age();
  int age;
  age = 32'h7fff_ffff;
  for (int s = 0; s < CP_SLOTS; s++) begin
    if (cp_live[s] && cp_age[s] < age) begin
      age = cp_age[s];
    end
  end
  return age;
endfunction

// Only groups older than every live checkpoint may retire
function automatic logic retire_ready();
  return ret_prf.size() > 0 && ret_age[0] < oldest_live_age();
endfunction

// Lanes in program order against a working copy of the table
task automatic model_group();
  prf_idx_t work [ARF_SIZE];
  int       pos;
  for (int a = 0; a < ARF_SIZE; a++) begin
    work[a] = m_table[a];
  end
  pos = 0;
  for (int i = 0; i < RENAME_WIDTH; i++) begin
    exp_rsp[i].prs1          = work[req[i].rs1];
    exp_rsp[i].prs2          = work[req[i].rs2];
    exp_rsp[i].prd           = m_free[pos];
    exp_rsp[i].prev_rd       = work[req[i].rd];
    exp_rsp[i].prev_rd_valid = req[i].rd_valid;
    if (req[i].rd_valid) begin
      work[req[i].rd] = m_free[pos];
      pos++;
      ret_prf.push_back(exp_rsp[i].prev_rd);
      ret_age.push_back(group_age);
    end
  end
  for (int a = 0; a < ARF_SIZE; a++) begin
    m_table[a] = work[a];
  end
  for (int i = 0; i < pos; i++) begin
    void'(m_free.pop_front());
  end
  group_age++;
endtask

task automatic model_check(input cp_idx_t slot);
  for (int a = 0; a < ARF_SIZE; a++) begin
    cp_table[slot][a] = m_table[a];
  end
  for (int i = 0; i < m_free.size(); i++) begin
    cp_free[slot][i] = m_free[i];
  end
  cp_len[slot]  = m_free.size();
  cp_age[slot]  = group_age;
  cp_live[slot] = 1'b1;
endtask

task automatic model_recover(input cp_idx_t slot);
  for (int a = 0; a < ARF_SIZE; a++) begin
    m_table[a] = cp_table[slot][a];
  end
  m_free.delete();
  for (int i = 0; i < cp_len[slot]; i++) begin
    m_free.push_back(cp_free[slot][i]);
  end
  // Groups at or after the checkpoint never happened
  while (ret_age.size() > 0 && ret_age[ret_age.size()-1] >= cp_age[slot]) begin
    void'(ret_age.pop_back());
    void'(ret_prf.pop_back());
  end
  for (int s = 0; s < CP_SLOTS; s++) begin
    cp_live[s] = 1'b0;
  end
endtask

task automatic model_retire(input prf_idx_t p);
  m_free.push_back(p);
  for (int s = 0; s < CP_SLOTS; s++) begin
    if (cp_live[s] && cp_len[s] < PRF_SIZE) begin
      cp_free[s][cp_len[s]] = p;
      cp_len[s]++;
    end
  end
endtask

// Branch resolved correctly, the oldest checkpoint is no longer needed
task automatic resolve_oldest();
  int age;
  age = oldest_live_age();
  for (int s = 0; s < CP_SLOTS; s++) begin
    if (cp_live[s] && cp_age[s] == age) begin
      cp_live[s] = 1'b0;
      break;
    end
  end
endtask

`endif

// File: bench/rename_unit_tb.sv
/*
 * Testbench for the rename stage
 * Xorshift stimulus, model compare, timeout and summary
 */
`timescale 1ns/1ps
`default_nettype none

module rename_unit_tb
  import rename_pkg::*;
();

  localparam int NUM_CYCLES = 2000;
  // Run length plus a quarter for reset and slack
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;

  logic                    clock;
  logic                    reset;
  logic                    rename;
  rename_req_t             req [RENAME_WIDTH];
  rename_rsp_t             rsp [RENAME_WIDTH];
  logic                    allocatable;
  logic                    check;
  cp_idx_t                 check_idx;
  logic                    recover;
  cp_idx_t                 recover_idx;
  logic [RENAME_WIDTH-1:0] retire_valid;
  prf_idx_t                retire_prf [RENAME_WIDTH];

  rename_rsp_t exp_rsp [RENAME_WIDTH];
  logic [31:0] rng;
  int          rsp_errors = 0;
  int          bit_errors = 0;
  int          cycle_count = 0;

  `include "rename_model.svh"

  rename_unit #(
    .arf_size     (ARF_SIZE),
    .prf_size     (PRF_SIZE),
    .rename_width (RENAME_WIDTH),
    .cp_slots     (CP_SLOTS)
  ) dut_i (
    .clock        (clock),
    .reset        (reset),
    .rename       (rename),
    .req          (req),
    .rsp          (rsp),
    .allocatable  (allocatable),
    .check        (check),
    .check_idx    (check_idx),
    .recover      (recover),
    .recover_idx  (recover_idx),
    .retire_valid (retire_valid),
    .retire_prf   (retire_prf)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped by the cycle limit after %0d cycles", cycle_count);
      $display("Some tests failed");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Half the picks from r0..r7 so lanes collide often
  function automatic arf_idx_t pick_arf(input logic [7:0] bits);
    return bits[7] ? arf_idx_t'(bits[2:0]) : bits[4:0];
  endfunction

  function automatic rename_req_t make_req(input logic v, input int s1, input int s2,
                                           input int d);
    rename_req_t r;
    r.rd_valid = v;
    r.rs1      = arf_idx_t'(s1);
    r.rs2      = arf_idx_t'(s2);
    r.rd       = arf_idx_t'(d);
    return r;
  endfunction

  task automatic check_rsp(input string name, input rename_rsp_t got, input rename_rsp_t exp);
    if (got !== exp) begin
      rsp_errors++;
      $display("Fail %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errors++;
      $display("Fail %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////
  task automatic drive_inputs(input int cyc);
    logic [31:0] r;
    int          s;
    rng = xorshift32(rng);
    r = rng;
    check        = 1'b0;
    recover      = 1'b0;
    retire_valid = '0;
    if (cyc == 0) begin
      // No dependencies, fresh registers in lane order
      rename = 1'b1;
      req[0] = make_req(1'b1, 1, 2, 5);
      req[1] = make_req(1'b1, 6, 7, 8);
    end else if (cyc == 1) begin
      // Lane 1 reads and overwrites lane 0's rd
      rename = 1'b1;
      req[0] = make_req(1'b1, 3, 4, 9);
      req[1] = make_req(1'b1, 9, 9, 9);
    end else begin
      rename = r[0] | r[1];
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        rng = xorshift32(rng);
        req[i].rd_valid = rng[24] | rng[25];
        req[i].rs1      = pick_arf(rng[7:0]);
        req[i].rs2      = pick_arf(rng[15:8]);
        req[i].rd       = pick_arf(rng[23:16]);
      end
      if (r[7:4] == 4'd0 && oldest_live_age() != 32'h7fff_ffff) begin
        for (int k = 0; k < CP_SLOTS; k++) begin
          s = (r[9:8] + k) % CP_SLOTS;
          if (!recover && cp_live[s]) begin
            recover     = 1'b1;
            recover_idx = cp_idx_t'(s);
          end
        end
      end else if (r[7:4] == 4'd1) begin
        resolve_oldest();
      end
      if (!recover && r[12:10] == 3'd0) begin
        check     = 1'b1;
        check_idx = r[14:13];
      end
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (r[16+i] && retire_ready()) begin
          retire_valid[i] = 1'b1;
          retire_prf[i]   = ret_prf.pop_front();
          void'(ret_age.pop_front());
        end
      end
    end
  endtask

  // Runs before the edge, in the order the DUT sees it
  task automatic check_and_update();
    logic alloc_exp;
    logic grant_exp;
    alloc_exp = m_free.size() >= RENAME_WIDTH;
    check_bit("allocatable", allocatable, alloc_exp);
    grant_exp = rename && !recover && alloc_exp;
    if (check) begin
      model_check(check_idx);
    end
    if (recover) begin
      model_recover(recover_idx);
    end else if (grant_exp) begin
      model_group();
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        check_rsp($sformatf("rsp[%0d]", i), rsp[i], exp_rsp[i]);
      end
    end
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (retire_valid[i]) begin
        model_retire(retire_prf[i]);
      end
    end
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    rename       = 1'b0;
    check        = 1'b0;
    check_idx    = '0;
    recover      = 1'b0;
    recover_idx  = '0;
    retire_valid = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      req[i]        = make_req(1'b0, 0, 0, 0);
      retire_prf[i] = '0;
    end
    rng = 32'd31369;
    model_reset();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      drive_inputs(cyc);
      #2;
      check_and_update();
      @(posedge clock);
      #1;
    end
    $display("Errors: rsp %0d, allocatable %0d", rsp_errors, bit_errors);
    if (rsp_errors == 0 && bit_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: common/rename_if.sv
/*
 * alloc_if carries register requests and grants between map table and free list
 * ckpt_if carries snapshots to the checkpoint store and saved state back
 */
`timescale 1ns/1ps
`default_nettype none

interface alloc_if
  import rename_pkg::*;
#(
  parameter int rename_width = RENAME_WIDTH
) ();

  logic [rename_width-1:0] need;
  logic                    grant;
  prf_idx_t                new_prf [rename_width];
  logic                    allocatable;

  modport map_side (
    output need,
    input  grant,
    input  new_prf
  );

  modport list_side (
    input  need,
    output grant,
    output new_prf,
    output allocatable
  );

endinterface

interface ckpt_if
  import rename_pkg::*;
#(
  parameter int arf_size = ARF_SIZE
) ();

  // Live state going in
  prf_idx_t map_snapshot [arf_size];
  fl_ptr_t  head_snapshot;

  // Slot contents at recover_idx
  prf_idx_t saved_map [arf_size];
  fl_ptr_t  saved_head;

  modport map_side (
    output map_snapshot,
    input  saved_map
  );

  modport list_side (
    output head_snapshot,
    input  saved_head
  );

  modport store_side (
    input  map_snapshot,
    input  head_snapshot,
    output saved_map,
    output saved_head
  );

endinterface

`default_nettype wire

// File: common/rename_pkg.sv
/*
 * Sizes, index types and per-lane request and response structs
 * shared by the rename stage
 */
`default_nettype none

package rename_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////
  localparam int ARF_SIZE     = 32;
  localparam int PRF_SIZE     = 64;
  localparam int RENAME_WIDTH = 2;
  localparam int CP_SLOTS     = 4;

  // Free-list queue depth, kept a power of two so the pointers wrap cleanly
  localparam int FL_DEPTH = PRF_SIZE - ARF_SIZE;
  localparam int FL_IDX_W = $clog2(FL_DEPTH);

  //////////////////////////////
  // Index types
  //////////////////////////////
  typedef logic [4:0] arf_idx_t;
  typedef logic [5:0] prf_idx_t;
  typedef logic [1:0] cp_idx_t;

  // Extra top bit tells a full queue from an empty one
  typedef logic [FL_IDX_W:0] fl_ptr_t;

  // One lane of a rename group
  typedef struct packed {
    logic     rd_valid;
    arf_idx_t rs1;
    arf_idx_t rs2;
    arf_idx_t rd;
  } rename_req_t;

  typedef struct packed {
    prf_idx_t prs1;
    prf_idx_t prs2;
    prf_idx_t prd;
    prf_idx_t prev_rd;
    logic     prev_rd_valid;
  } rename_rsp_t;

  // Next-state choice for the map table
  typedef enum logic [1:0] {
    MAP_HOLD,
    MAP_RENAME,
    MAP_RESTORE
  } map_state_t;

endpackage

`default_nettype wire

// File: rename/checkpoint_store.sv
/*
 * Checkpoint slots holding map table and free-list head copies
 */
`timescale 1ns/1ps
`default_nettype none

module checkpoint_store
  import rename_pkg::*;
#(
  parameter int cp_slots = CP_SLOTS,
  parameter int arf_size = ARF_SIZE
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        check,
  input  cp_idx_t     check_idx,
  input  logic        recover,
  input  cp_idx_t     recover_idx,
  ckpt_if.store_side  ckpt
);

  prf_idx_t            map_slots  [cp_slots][arf_size];
  fl_ptr_t             head_slots [cp_slots];
  logic [cp_slots-1:0] slot_valid;

  // Saves the state seen before the edge
  always_ff @(posedge clock) begin
    if (check) begin
      map_slots[check_idx]  <= ckpt.map_snapshot;
      head_slots[check_idx] <= ckpt.head_snapshot;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= '0;
    end else if (check) begin
      slot_valid[check_idx] <= 1'b1;
    end
  end

  assign ckpt.saved_map  = map_slots[recover_idx];
  assign ckpt.saved_head = head_slots[recover_idx];

  // Recover only from a slot saved since reset
  recover_from_saved: assert property (
    @(posedge clock) disable iff (reset)
    recover |-> slot_valid[recover_idx]
  );

endmodule

`default_nettype wire

// File: rename/free_list.sv
/*
 * Circular queue of free physical registers
 * Allocation from the head, release at the tail, head restore on recover
 */
`timescale 1ns/1ps
`default_nettype none

module free_list
  import rename_pkg::*;
#(
  parameter int arf_size     = ARF_SIZE,
  parameter int prf_size     = PRF_SIZE,
  parameter int rename_width = RENAME_WIDTH
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    rename,
  input  logic                    recover,
  input  logic [rename_width-1:0] retire_valid,
  input  prf_idx_t                retire_prf [rename_width],
  alloc_if.list_side              alloc,
  ckpt_if.list_side               ckpt
);

  localparam int depth = prf_size - arf_size;
  localparam int idx_w = $clog2(depth);

  prf_idx_t queue [depth];
  fl_ptr_t  head;
  fl_ptr_t  tail;
  fl_ptr_t  head_next;
  fl_ptr_t  tail_next;
  fl_ptr_t  push_ptr [rename_width];
  fl_ptr_t  count;

  assign count             = tail - head;
  assign alloc.allocatable = count >= fl_ptr_t'(rename_width);
  assign alloc.grant       = rename && !recover && alloc.allocatable;
  assign ckpt.head_snapshot = head;

  //////////////////////////////
  // Allocation
  //////////////////////////////
  always_comb begin
    fl_ptr_t rd_ptr;
    rd_ptr = head;
    for (int i = 0; i < rename_width; i++) begin
      alloc.new_prf[i] = queue[rd_ptr[idx_w-1:0]];
      // Lanes without rd leave the entry for the next lane
      if (alloc.need[i]) begin
        rd_ptr = rd_ptr + 1'b1;
      end
    end
    head_next = rd_ptr;
  end

  // Release slots in lane order
  always_comb begin
    fl_ptr_t wr_ptr;
    wr_ptr = tail;
    for (int i = 0; i < rename_width; i++) begin
      push_ptr[i] = wr_ptr;
      if (retire_valid[i]) begin
        wr_ptr = wr_ptr + 1'b1;
      end
    end
    tail_next = wr_ptr;
  end

  //////////////////////////////
  // State
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= fl_ptr_t'(depth);
    end else begin
      if (recover) begin
        head <= ckpt.saved_head;
      end else if (alloc.grant) begin
        head <= head_next;
      end
      tail <= tail_next;
    end
  end

  // Starts out holding every register above the architectural ones
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        queue[i] <= prf_idx_t'(arf_size + i);
      end
    end else begin
      for (int i = 0; i < rename_width; i++) begin
        if (retire_valid[i]) begin
          queue[push_ptr[i][idx_w-1:0]] <= retire_prf[i];
        end
      end
    end
  end

  no_overflow: assert property (
    @(posedge clock) disable iff (reset)
    count <= fl_ptr_t'(depth)
  );

endmodule

`default_nettype wire

// File: rename/map_table.sv
/*
 * Architectural to physical mapping table with in-group
 * RAW and WAW resolution, rename commit and checkpoint restore
 */
`timescale 1ns/1ps
`default_nettype none

module map_table
  import rename_pkg::*;
#(
  parameter int arf_size     = ARF_SIZE,
  parameter int rename_width = RENAME_WIDTH
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        recover,
  input  rename_req_t req [rename_width],
  output rename_rsp_t rsp [rename_width],
  alloc_if.map_side   alloc,
  ckpt_if.map_side    ckpt
);

  prf_idx_t   table_q    [arf_size];
  prf_idx_t   table_work [arf_size];
  map_state_t state_sel;
  logic       fresh_clash;

  //////////////////////////////
  // Lane walk in program order
  //////////////////////////////
  always_comb begin
    table_work = table_q;
    for (int i = 0; i < rename_width; i++) begin
      alloc.need[i] = req[i].rd_valid;
      // Sources see earlier lanes' destinations
      rsp[i].prs1 = table_work[req[i].rs1];
      rsp[i].prs2 = table_work[req[i].rs2];
      rsp[i].prd  = alloc.new_prf[i];
      // Mapping left behind by earlier lanes
      rsp[i].prev_rd       = table_work[req[i].rd];
      rsp[i].prev_rd_valid = req[i].rd_valid;
      if (req[i].rd_valid) begin
        table_work[req[i].rd] = alloc.new_prf[i];
      end
    end
  end

  // Recover wins over a group offered in the same cycle
  always_comb begin
    if (recover) begin
      state_sel = MAP_RESTORE;
    end else if (alloc.grant) begin
      state_sel = MAP_RENAME;
    end else begin
      state_sel = MAP_HOLD;
    end
  end

  //////////////////////////////
  // Table update
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity mapping
      for (int i = 0; i < arf_size; i++) begin
        table_q[i] <= prf_idx_t'(i);
      end
    end else begin
      case (state_sel)
        MAP_RENAME:  table_q <= table_work;
        MAP_RESTORE: table_q <= ckpt.saved_map;
        default:     table_q <= table_q;
      endcase
    end
  end

  assign ckpt.map_snapshot = table_q;

  // Register handed out while some entry still maps to it
  always_comb begin
    fresh_clash = 1'b0;
    for (int i = 0; i < rename_width; i++) begin
      for (int a = 0; a < arf_size; a++) begin
        if (alloc.need[i] && table_q[a] == alloc.new_prf[i]) begin
          fresh_clash = 1'b1;
        end
      end
    end
  end

  // A fresh register must not still be mapped
  fresh_not_mapped: assert property (
    @(posedge clock) disable iff (reset)
    alloc.grant |-> !fresh_clash
  );

endmodule

`default_nettype wire

// File: rename_unit.f
+incdir+bench
common/rename_pkg.sv
common/rename_if.sv
rename/map_table.sv
rename/free_list.sv
rename/checkpoint_store.sv
verilog/rename_unit.sv
bench/rename_unit_tb.sv

// File: verilog/rename_unit.sv
/*
 * Rename stage top level
 * Map table, free list and checkpoint store on plain ports
 */
`timescale 1ns/1ps
`default_nettype none

module rename_unit
  import rename_pkg::*;
#(
  parameter int arf_size     = ARF_SIZE,
  parameter int prf_size     = PRF_SIZE,
  parameter int rename_width = RENAME_WIDTH,
  parameter int cp_slots     = CP_SLOTS
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    rename,
  input  rename_req_t             req [rename_width],
  output rename_rsp_t             rsp [rename_width],
  output logic                    allocatable,
  input  logic                    check,
  input  cp_idx_t                 check_idx,
  input  logic                    recover,
  input  cp_idx_t                 recover_idx,
  input  logic [rename_width-1:0] retire_valid,
  input  prf_idx_t                retire_prf [rename_width]
);

  alloc_if #(.rename_width(rename_width)) alloc_bus ();
  ckpt_if  #(.arf_size(arf_size))         ckpt_bus ();

  map_table #(
    .arf_size     (arf_size),
    .rename_width (rename_width)
  ) map_table_i (
    .clock   (clock),
    .reset   (reset),
    .recover (recover),
    .req     (req),
    .rsp     (rsp),
    .alloc   (alloc_bus.map_side),
    .ckpt    (ckpt_bus.map_side)
  );

  free_list #(
    .arf_size     (arf_size),
    .prf_size     (prf_size),
    .rename_width (rename_width)
  ) free_list_i (
    .clock        (clock),
    .reset        (reset),
    .rename       (rename),
    .recover      (recover),
    .retire_valid (retire_valid),
    .retire_prf   (retire_prf),
    .alloc        (alloc_bus.list_side),
    .ckpt         (ckpt_bus.list_side)
  );

  checkpoint_store #(
    .cp_slots (cp_slots),
    .arf_size (arf_size)
  ) checkpoint_store_i (
    .clock       (clock),
    .reset       (reset),
    .check       (check),
    .check_idx   (check_idx),
    .recover     (recover),
    .recover_idx (recover_idx),
    .ckpt        (ckpt_bus.store_side)
  );

  assign allocatable = alloc_bus.allocatable;

endmodule

`default_nettype wire
